/* src/aluPkg.sv */
package aluPkg;

	localparam int dataWidth = 16; // Operand and result width.
	localparam int halfWidth = 8; // Multiplier factor width.
	localparam int opWidth = 5;

	typedef logic [dataWidth-1:0] wordT;
	typedef logic [halfWidth-1:0] halfT;

	typedef enum logic [opWidth-1:0] {
		opAdd = 5'd0,
		opInc = 5'd1,
		opSub = 5'd2,
		opDec = 5'd3,
		opMul = 5'd4,
		opShr = 5'd8,
		opAnd = 5'd16,
		opXor = 5'd17,
		opOr  = 5'd18,
		opNot = 5'd19,
		opShl = 5'd24
	} aluOpT;

	// One request as seen by the operand stage, 38 bits.
	typedef struct packed {
		aluOpT opcode;
		wordT  operandA;
		wordT  operandB;
		logic  rotate; // Shifts wrap the outgoing bit around.
	} aluReqT;

endpackage

/* src/operandCapture.sv */
`timescale 1ns/1ps

module operandCapture
	import aluPkg::*;
(
	input  logic   clk,
	input  logic   rstN,
	input  logic   start,
	input  aluReqT req,
	output aluReqT stageReq,
	output logic   stageValid
);

	// Request register; holds between starts so the units see stable operands.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			stageReq <= '0;
		end else if (start) begin
			stageReq <= req;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			stageValid <= 1'b0;
		end else begin
			stageValid <= start; // One cycle per accepted request.
		end
	end

endmodule

/* src/arithUnit.sv */
`timescale 1ns/1ps

module arithUnit
	import aluPkg::*;
(
	input  aluReqT stageReq,
	output wordT   arithResult
);

	wordT operand;
	wordT addend;
	logic carryIn;
	logic [dataWidth-1:0] carry;
	wordT sum;

	assign operand = stageReq.operandA;

	// Second addend and carry-in turn the one adder into all four operations.
	always_comb begin
		addend = stageReq.operandB;
		carryIn = 1'b0;
		case (stageReq.opcode)
			opAdd: begin
				addend = stageReq.operandB;
				carryIn = 1'b0;
			end
			opSub: begin
				addend = ~stageReq.operandB; // Two's complement of B.
				carryIn = 1'b1;
			end
			opInc: begin
				addend = '0;
				carryIn = 1'b1;
			end
			opDec: begin
				addend = '1; // Adding all ones is minus one.
				carryIn = 1'b0;
			end
			default: begin
				addend = stageReq.operandB;
				carryIn = 1'b0;
			end
		endcase
	end

	assign carry[0] = carryIn;

	// Ripple-carry chain of full-adder cells.
	for (genvar i = 0; i < dataWidth; i++) begin : gCell
		assign sum[i] = operand[i] ^ addend[i] ^ carry[i];
		if (i < dataWidth - 1) begin : gCarry
			assign carry[i+1] = (operand[i] & addend[i])
				| ((operand[i] ^ addend[i]) & carry[i]);
		end
	end

	assign arithResult = sum; // Carry out of the top is dropped, modulo 2^16.

endmodule

/* src/arrayMultiplier.sv */
`timescale 1ns/1ps

module arrayMultiplier
	import aluPkg::*;
(
	input  aluReqT stageReq,
	output wordT   mulResult
);

	halfT factorA;
	halfT factorB;

	logic [halfWidth-1:0][halfWidth-1:0] partial; // One row per bit of factorA.
	logic [halfWidth-1:0][halfWidth-1:0] rowSum;
	logic [halfWidth-1:0] rowCarry;

	// Only the low bytes take part.
	assign factorA = stageReq.operandA[halfWidth-1:0];
	assign factorB = stageReq.operandB[halfWidth-1:0];

	for (genvar r = 0; r < halfWidth; r++) begin : gPartial
		assign partial[r] = factorB & {halfWidth{factorA[r]}};
	end

	// First row enters the array unchanged.
	assign rowSum[0] = partial[0];
	assign rowCarry[0] = 1'b0;

	for (genvar r = 1; r < halfWidth; r++) begin : gRow
		halfT shifted;
		logic [halfWidth:0] chain;

		// Previous sum moves down one place, its carry comes in at the top.
		assign shifted = {rowCarry[r-1], rowSum[r-1][halfWidth-1:1]};
		assign chain[0] = 1'b0;

		for (genvar i = 0; i < halfWidth; i++) begin : gCell
			assign rowSum[r][i] = partial[r][i] ^ shifted[i] ^ chain[i];
			assign chain[i+1] = (partial[r][i] & shifted[i])
				| ((partial[r][i] ^ shifted[i]) & chain[i]);
		end

		assign rowCarry[r] = chain[halfWidth];
	end

	// Each row retires its low bit as one product bit.
	for (genvar r = 0; r < halfWidth; r++) begin : gLowBits
		assign mulResult[r] = rowSum[r][0];
	end

	// The last row supplies the upper byte.
	assign mulResult[dataWidth-2:halfWidth] = rowSum[halfWidth-1][halfWidth-1:1];
	assign mulResult[dataWidth-1] = rowCarry[halfWidth-1];

endmodule

/* src/logicShiftUnit.sv */
`timescale 1ns/1ps

module logicShiftUnit
	import aluPkg::*;
(
	input  aluReqT stageReq,
	output wordT   logicResult
);

	wordT opA;
	wordT opB;
	logic wrapLow;
	logic wrapHigh;

	assign opA = stageReq.operandA;
	assign opB = stageReq.operandB;

	// Bits that come back in at the far end when rotating.
	assign wrapLow = stageReq.rotate & opA[0];
	assign wrapHigh = stageReq.rotate & opA[dataWidth-1];

	always_comb begin
		case (stageReq.opcode)
			opAnd: begin
				logicResult = opA & opB;
			end
			opXor: begin
				logicResult = opA ^ opB;
			end
			opOr: begin
				logicResult = opA | opB;
			end
			opNot: begin
				logicResult = ~opA;
			end
			opShr: begin
				logicResult = {wrapLow, opA[dataWidth-1:1]};
			end
			opShl: begin
				logicResult = {opA[dataWidth-2:0], wrapHigh};
			end
			default: begin
				logicResult = '0; // Not a logic opcode.
			end
		endcase
	end

endmodule

/* src/resultSelect.sv */
`timescale 1ns/1ps

module resultSelect
	import aluPkg::*;
(
	input  logic  clk,
	input  logic  rstN,
	input  aluOpT opcode,
	input  logic  stageValid,
	input  wordT  arithResult,
	input  wordT  mulResult,
	input  wordT  logicResult,
	output wordT  result,
	output logic  resultValid
);

	wordT chosen;

	// Opcode to unit map.
	always_comb begin
		case (opcode)
			opAdd, opInc, opSub, opDec: begin
				chosen = arithResult;
			end
			opMul: begin
				chosen = mulResult;
			end
			opShr, opShl, opAnd, opXor, opOr, opNot: begin
				chosen = logicResult;
			end
			default: begin
				chosen = '0; // Unused codes read as zero.
			end
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			result <= '0;
		end else if (stageValid) begin
			result <= chosen;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			resultValid <= 1'b0;
		end else begin
			resultValid <= stageValid;
		end
	end

endmodule

/* src/aluTop.sv */
`timescale 1ns/1ps

module aluTop
	import aluPkg::*;
(
	input  logic   clk,
	input  logic   rstN,
	input  logic   start,
	input  aluReqT req,
	output wordT   result,
	output logic   resultValid
);

	aluReqT stageReq;
	logic   stageValid;
	wordT   arithResult;
	wordT   mulResult;
	wordT   logicResult;

	operandCapture iCapture (
		.clk        (clk),
		.rstN       (rstN),
		.start      (start),
		.req        (req),
		.stageReq   (stageReq),
		.stageValid (stageValid)
	);

	// The three units work in parallel on the captured request.
	arithUnit iArith (
		.stageReq    (stageReq),
		.arithResult (arithResult)
	);

	arrayMultiplier iMul (
		.stageReq  (stageReq),
		.mulResult (mulResult)
	);

	logicShiftUnit iLogic (
		.stageReq    (stageReq),
		.logicResult (logicResult)
	);

	resultSelect iSelect (
		.clk         (clk),
		.rstN        (rstN),
		.opcode      (stageReq.opcode),
		.stageValid  (stageValid),
		.arithResult (arithResult),
		.mulResult   (mulResult),
		.logicResult (logicResult),
		.result      (result),
		.resultValid (resultValid)
	);

endmodule

/* dv/aluTb.sv */
`timescale 1ns/1ps

module aluTb
	import aluPkg::*;
();

	localparam int clkPeriod = 100;
	localparam int driveDelay = 5;
	localparam int resetCycles = 2;
	localparam int numIdle = 3;
	localparam int numArithDirected = 8;
	localparam int numArithRandom = 40;
	localparam int numMulDirected = 4;
	localparam int numMulRandom = 20;
	localparam int numLogicDirected = 10;
	localparam int numLogicRandom = 20;
	localparam int numUnusedDirected = 3;
	localparam int numStreamSlots = 80;
	localparam int totalSlots = resetCycles + 2 * numIdle + numArithDirected + numArithRandom
		+ numMulDirected + numMulRandom + numLogicDirected + numLogicRandom
		+ numUnusedDirected + numStreamSlots;
	localparam int watchdogCycles = totalSlots + 10;

	logic   clk;
	logic   rstN;
	logic   start;
	aluReqT req;
	wordT   result;
	logic   resultValid;

	int     seed = 32'h0811570f;
	int     edgeCount = 0;
	int     checkedCount = 0;
	wordT   expQ[$];
	int     dueQ[$];
	string  nameQ[$];

	aluTop i_dut (
		.clk         (clk),
		.rstN        (rstN),
		.start       (start),
		.req         (req),
		.result      (result),
		.resultValid (resultValid)
	);

	always #(clkPeriod / 2) clk = ~clk;

	always @(posedge clk) begin
		edgeCount++;
	end

	task automatic abortRun(string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1);
	endtask

	task automatic checkResult(string name, wordT expVal, wordT actVal);
		if (actVal !== expVal) begin
			abortRun($sformatf("Fail %s: expected %h, actual %h", name, expVal, actVal));
		end
	endtask

	task automatic checkValid(string name, logic expVal, logic actVal);
		if (actVal !== expVal) begin
			abortRun($sformatf("Fail %s: expected valid %b, actual %b", name, expVal, actVal));
		end
	endtask

	// Expected result straight from the opcode rules.
	function automatic wordT aluModel(aluReqT r);
		wordT a;
		wordT b;
		wordT expVal;
		a = r.operandA;
		b = r.operandB;
		case (r.opcode)
			opAdd: expVal = a + b;
			opInc: expVal = a + 16'd1;
			opSub: expVal = a - b;
			opDec: expVal = a - 16'd1;
			opMul: expVal = wordT'(a[halfWidth-1:0]) * wordT'(b[halfWidth-1:0]);
			opShr: expVal = r.rotate ? {a[0], a[dataWidth-1:1]} : (a >> 1);
			opShl: expVal = r.rotate ? {a[dataWidth-2:0], a[dataWidth-1]} : (a << 1);
			opAnd: expVal = a & b;
			opXor: expVal = a ^ b;
			opOr:  expVal = a | b;
			opNot: expVal = ~a;
			default: expVal = '0; // Unused codes.
		endcase
		return expVal;
	endfunction

	function automatic aluReqT buildReq(aluOpT op, wordT a, wordT b, logic rot);
		aluReqT r;
		r.opcode = op;
		r.operandA = a;
		r.operandB = b;
		r.rotate = rot;
		return r;
	endfunction

	function automatic wordT randWord();
		return wordT'($random(seed));
	endfunction

	function automatic int randIndex(int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	function automatic aluOpT arithOpFor(int idx);
		case (idx)
			0: return opAdd;
			1: return opInc;
			2: return opSub;
			default: return opDec;
		endcase
	endfunction

	function automatic aluOpT logicOpFor(int idx);
		case (idx)
			0: return opAnd;
			1: return opXor;
			2: return opOr;
			3: return opNot;
			4: return opShr;
			default: return opShl;
		endcase
	endfunction

	task automatic sendReq(string name, aluReqT r);
		@(posedge clk);
		#driveDelay;
		start = 1'b1;
		req = r;
		expQ.push_back(aluModel(r));
		dueQ.push_back(edgeCount + 2); // Result visible two edges later.
		nameQ.push_back(name);
	endtask

	task automatic idleCycle();
		@(posedge clk);
		#driveDelay;
		start = 1'b0;
		req = buildReq(opAdd, randWord(), randWord(), 1'b0); // Must be ignored.
	endtask

	// Compare at the falling edge where outputs are settled.
	always @(negedge clk) begin : compareResults
		logic  due;
		string name;
		wordT  expVal;
		if (rstN) begin
			due = (dueQ.size() > 0) && (dueQ[0] == edgeCount);
			checkValid(due ? nameQ[0] : "idle", due, resultValid);
			if (resultValid) begin
				name = nameQ.pop_front();
				expVal = expQ.pop_front();
				void'(dueQ.pop_front());
				checkResult(name, expVal, result);
				checkedCount++;
			end else if (checkedCount == 0) begin
				checkResult("reset", '0, result); // Nothing has come out yet.
			end
		end
	end

	initial begin
		#(watchdogCycles * clkPeriod);
		abortRun("Timeout: the run did not finish within the expected time");
	end

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		start = 1'b0;
		req = '0;
		repeat (resetCycles) @(posedge clk);
		#driveDelay;
		rstN = 1'b1;
		repeat (numIdle) idleCycle();

		sendReq("add wrap", buildReq(opAdd, 16'hFFFF, 16'h0001, 1'b0));
		sendReq("sub wrap", buildReq(opSub, 16'h0000, 16'h0001, 1'b0));
		sendReq("inc wrap", buildReq(opInc, 16'hFFFF, 16'h1234, 1'b0));
		sendReq("dec wrap", buildReq(opDec, 16'h0000, 16'h5678, 1'b0));
		sendReq("add", buildReq(opAdd, 16'h1234, 16'h4321, 1'b0));
		sendReq("sub negative", buildReq(opSub, 16'h0005, 16'h0007, 1'b0));
		sendReq("inc", buildReq(opInc, 16'h7FFF, 16'h0000, 1'b0));
		sendReq("dec", buildReq(opDec, 16'h8000, 16'hFFFF, 1'b0));
		for (int i = 0; i < numArithRandom; i++) begin
			sendReq("arith random", buildReq(arithOpFor(randIndex(4)), randWord(), randWord(),
				1'b0));
		end

		sendReq("mul max", buildReq(opMul, 16'h00FF, 16'h00FF, 1'b0));
		sendReq("mul max upper", buildReq(opMul, 16'hFFFF, 16'hFFFF, 1'b0));
		sendReq("mul upper ignored", buildReq(opMul, 16'hAB03, 16'hCD05, 1'b0));
		sendReq("mul zero", buildReq(opMul, 16'h1200, 16'h00FF, 1'b0));
		for (int i = 0; i < numMulRandom; i++) begin
			sendReq("mul random", buildReq(opMul, randWord(), randWord(), 1'b0));
		end

		sendReq("and", buildReq(opAnd, 16'hF0F0, 16'hFF00, 1'b0));
		sendReq("xor", buildReq(opXor, 16'hF0F0, 16'hFF00, 1'b0));
		sendReq("or", buildReq(opOr, 16'hF0F0, 16'h0F00, 1'b0));
		sendReq("not", buildReq(opNot, 16'h1234, 16'hFFFF, 1'b0));
		sendReq("shr", buildReq(opShr, 16'h8001, 16'h0000, 1'b0));
		sendReq("shr rotate", buildReq(opShr, 16'h8001, 16'h0000, 1'b1));
		sendReq("shl", buildReq(opShl, 16'h8001, 16'h0000, 1'b0));
		sendReq("shl rotate", buildReq(opShl, 16'h8001, 16'h0000, 1'b1));
		sendReq("shr rotate low", buildReq(opShr, 16'h0001, 16'h0000, 1'b1));
		sendReq("shl rotate high", buildReq(opShl, 16'h8000, 16'h0000, 1'b1));
		for (int i = 0; i < numLogicRandom; i++) begin
			sendReq("logic random", buildReq(logicOpFor(randIndex(6)), randWord(), randWord(),
				randIndex(2) == 1));
		end

		sendReq("unused 5", buildReq(aluOpT'(5'd5), 16'h1234, 16'h5678, 1'b0));
		sendReq("unused 9", buildReq(aluOpT'(5'd9), 16'hFFFF, 16'h0001, 1'b1));
		sendReq("unused 31", buildReq(aluOpT'(5'd31), 16'hA5A5, 16'h5A5A, 1'b0));
		// Random gaps and all 32 codes.
		for (int i = 0; i < numStreamSlots; i++) begin
			if (randIndex(4) == 0) begin
				idleCycle();
			end else begin
				sendReq("stream", buildReq(aluOpT'(randIndex(32)), randWord(), randWord(),
					randIndex(2) == 1));
			end
		end

		repeat (numIdle) idleCycle();
		while (expQ.size() != 0) begin
			@(negedge clk);
		end
		@(negedge clk);
		$display("all tests passed");
		$finish;
	end

endmodule

/* flist.f */
src/aluPkg.sv
src/operandCapture.sv
src/arithUnit.sv
src/arrayMultiplier.sv
src/logicShiftUnit.sv
src/resultSelect.sv
src/aluTop.sv
dv/aluTb.sv
